// ==== all.f ====
logic/ps2_frame_pkg.sv
logic/keyboard_code_pkg.sv
logic/ps2_frame_receiver.sv
logic/scan_code_decoder.sv
logic/ascii_translator.sv
logic/key_event_buffer.sv
logic/ps2_keyboard_rx.sv
tests/ps2_keyboard_rx_sva.sv
tests/ps2_keyboard_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the PS/2 receiver testbench
mkdir -p build &&
  verilator --binary --timing --assert -f all.f --top-module ps2_keyboard_rx_tb \
    -Mdir build -o sim_bin > build/compile.log 2>&1 ||
  { cat build/compile.log; echo "compile failed"; exit 1; }
./build/sim_bin > build/sim.log 2>&1
cat build/sim.log
grep -qx "sim passed" build/sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/ps2_keyboard_rx_tb.sv ====
/*
  Drives PS/2 frames at 16 clocks per bit into ps2_keyboard_rx. Each key
  event is accepted before the next frame, so shift state is fixed at transfer.
*/
`default_nettype none

module ps2_keyboard_rx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int frames_sent = 20;                           // every frame below, partial included
  localparam int cycle_limit = frames_sent * 11 * 16 + 1000;  // bits x bit period + idle margin

  logic clk;
  logic reset;
  logic ps2_clk;
  logic ps2_data;
  logic rx_ready;
  logic rx_valid;
  logic rx_extended;
  logic rx_released;
  logic rx_shift_on;
  keyboard_code_pkg::scan_code_t rx_scan_code;
  keyboard_code_pkg::ascii_t     rx_ascii;

  int          errors = 0;
  int          cycle_count = 0;
  logic [31:0] lfsr_state = 32'h29e51a6c;
  logic [18:0] exp_q[$];     // {shift, extended, released, scan code, ascii}
  logic [18:0] exp_entry;

  ps2_keyboard_rx #(
    .watchdog_cycles (64),
    .trap_shift_keys (1'b1)
  ) i_dut (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .rx_ready     (rx_ready),
    .rx_valid     (rx_valid),
    .rx_extended  (rx_extended),
    .rx_released  (rx_released),
    .rx_shift_on  (rx_shift_on),
    .rx_scan_code (rx_scan_code),
    .rx_ascii     (rx_ascii)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 40 ns period
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
  endfunction

  task automatic random_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};   // one step per bit
    end
  endtask

  function automatic logic [10:0] frame_word(input keyboard_code_pkg::scan_code_t data);
    return {1'b1, ~^data, data, 1'b0};        // stop, odd parity, data, start
  endfunction

  // lsb first, data set one clock before the falling edge
  task automatic drive_bits(input logic [10:0] word, input int count);
    for (int i = 0; i < count; i++)
    begin
      ps2_data = word[i];
      @(negedge clk);
      ps2_clk = 1'b0;
      repeat (8) @(negedge clk);
      ps2_clk = 1'b1;
      repeat (7) @(negedge clk);
    end
    ps2_data = 1'b1;                          // back to idle
  endtask

  task automatic send_frame(input keyboard_code_pkg::scan_code_t data);
    drive_bits(frame_word(data), 11);
  endtask

  // random stall of 0..7 cycles before the accept
  task automatic accept_event;
    int stall;
    while (!rx_valid) @(negedge clk);
    random_bits(3, stall);
    repeat (stall) @(negedge clk);
    rx_ready = 1'b1;
    @(negedge clk);
    rx_ready = 1'b0;
  endtask

  task automatic deliver_key(input keyboard_code_pkg::scan_code_t scan,
                             input keyboard_code_pkg::ascii_t ascii,
                             input logic ext, input logic rel, input logic shift);
    exp_q.push_back({shift, ext, rel, scan, ascii});
    send_frame(scan);
    accept_event();
  endtask

  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
    assert (actual == expected)
    else
    begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    assert (actual == expected)
    else
    begin
      $display("Mismatch at %0t: %s expected %0b got %0b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task report_and_finish;
    int total;
    total = errors + i_dut.i_sva.fail_count;
    $display("closing report: %0d check errors, %0d assertion failures, %0d in total",
             errors, i_dut.i_sva.fail_count, total);
    if (total == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  // ------------------------------
  // scoreboard at each transfer
  // ------------------------------
  always @(posedge clk)
  begin
    if (!reset && rx_valid && rx_ready)
    begin
      assert (exp_q.size() != 0)
      else
      begin
        $display("error at %0t: key event %h delivered but none expected", $time, rx_scan_code);
        errors++;
      end
      if (exp_q.size() != 0)
      begin
        exp_entry = exp_q.pop_front();
        check_value("rx_ascii", rx_ascii, exp_entry[7:0]);
        check_value("rx_scan_code", rx_scan_code, exp_entry[15:8]);
        check_flag("rx_released", rx_released, exp_entry[16]);
        check_flag("rx_extended", rx_extended, exp_entry[17]);
        check_flag("rx_shift_on", rx_shift_on, exp_entry[18]);
      end
    end
  end

  initial
  begin
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("error: run did not finish within %0d cycles", cycle_limit);
    errors++;
    report_and_finish();
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial
  begin
    reset    = 1'b1;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    rx_ready = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    check_flag("rx_valid", rx_valid, 1'b0);
    check_flag("rx_shift_on", rx_shift_on, 1'b0);
    check_flag("rx_extended", rx_extended, 1'b0);
    check_flag("rx_released", rx_released, 1'b0);
    check_value("rx_scan_code", rx_scan_code, 8'h00);
    check_value("rx_ascii", rx_ascii, 8'h00);

    deliver_key(8'h1C, 8'h61, 1'b0, 1'b0, 1'b0);                 // plain 'a'
    send_frame(keyboard_code_pkg::left_shift_code);               // trapped
    deliver_key(8'h1C, 8'h41, 1'b0, 1'b0, 1'b1);                 // 'A'
    send_frame(keyboard_code_pkg::release_code);
    send_frame(keyboard_code_pkg::left_shift_code);
    repeat (10) @(negedge clk);
    check_flag("rx_shift_on", rx_shift_on, 1'b0);
    check_flag("rx_valid", rx_valid, 1'b0);                      // shift break is trapped too

    send_frame(keyboard_code_pkg::extend_code);
    send_frame(keyboard_code_pkg::release_code);
    deliver_key(8'h5A, 8'h0D, 1'b1, 1'b1, 1'b0);                 // extended enter release
    deliver_key(8'h1C, 8'h61, 1'b0, 1'b0, 1'b0);                 // flags cleared again
    deliver_key(8'h05, keyboard_code_pkg::unknown_ascii, 1'b0, 1'b0, 1'b0);

    // second key arrives while the first is stalled and is dropped
    exp_q.push_back({1'b0, 1'b0, 1'b0, 8'h1C, 8'h61});
    send_frame(8'h1C);
    send_frame(8'h32);
    repeat (20) @(negedge clk);
    accept_event();
    rx_ready = 1'b1;
    repeat (40) @(negedge clk);
    rx_ready = 1'b0;
    check_flag("rx_valid", rx_valid, 1'b0);

    deliver_key(8'h16, 8'h31, 1'b0, 1'b0, 1'b0);                 // random stalls from here
    deliver_key(8'h1E, 8'h32, 1'b0, 1'b0, 1'b0);
    deliver_key(8'h24, 8'h65, 1'b0, 1'b0, 1'b0);
    deliver_key(8'h29, 8'h20, 1'b0, 1'b0, 1'b0);
    deliver_key(8'h4A, 8'h2F, 1'b0, 1'b0, 1'b0);
    deliver_key(8'h66, 8'h08, 1'b0, 1'b0, 1'b0);

    // watchdog drops a 4-bit fragment
    drive_bits(frame_word(8'h2B), 4);
    repeat (100) @(negedge clk);
    deliver_key(8'h2B, 8'h66, 1'b0, 1'b0, 1'b0);

    repeat (10) @(negedge clk);
    assert (exp_q.size() == 0)
    else
    begin
      $display("error: %0d expected key events were never delivered", exp_q.size());
      errors++;
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

// ==== tests/ps2_keyboard_rx_sva.sv ====
/*
  Handshake checks bound into ps2_keyboard_rx. key_valid is the internal
  decoder pulse. fail_count is read by the testbench at the end of the run.
*/
`default_nettype none

module ps2_keyboard_rx_sva (
  input logic                          clk,
  input logic                          reset,
  input logic                          key_valid,
  input logic                          rx_ready,
  input logic                          rx_valid,
  input logic                          rx_extended,
  input logic                          rx_released,
  input keyboard_code_pkg::scan_code_t rx_scan_code,
  input keyboard_code_pkg::ascii_t     rx_ascii
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // ------------------------------
  // output handshake
  // ------------------------------
  // stalled event keeps valid and payload
  held_event_stable: assert property (@(posedge clk) disable iff (reset)
    rx_valid && !rx_ready |=> rx_valid
      && $stable({rx_extended, rx_released, rx_scan_code, rx_ascii}))
  else
  begin
    $error("held key event changed or vanished while rx_ready was low");
    fail_count++;
  end

  // sync reset, so valid is low one edge later
  valid_low_after_reset: assert property (@(posedge clk) reset |=> !rx_valid)
  else
  begin
    $error("rx_valid was high in the cycle after reset");
    fail_count++;
  end

  valid_needs_key_event: assert property (@(posedge clk) disable iff (reset)
    $rose(rx_valid) |-> $past(key_valid))
  else
  begin
    $error("rx_valid rose without a key event from the decoder");
    fail_count++;
  end

endmodule

bind ps2_keyboard_rx ps2_keyboard_rx_sva i_sva (
  .clk          (clk),
  .reset        (reset),
  .key_valid    (key_valid),
  .rx_ready     (rx_ready),
  .rx_valid     (rx_valid),
  .rx_extended  (rx_extended),
  .rx_released  (rx_released),
  .rx_scan_code (rx_scan_code),
  .rx_ascii     (rx_ascii)
);

`default_nettype wire

// ==== logic/ps2_keyboard_rx.sv ====
/*
  PS/2 keyboard receive path, lines used as inputs only. Key events leave
  on a valid/ready port, rx_shift_on follows the live shift key state.
*/
`default_nettype none

module ps2_keyboard_rx #(
  parameter int watchdog_cycles = 102,    // about 60 us of clk
  parameter bit trap_shift_keys = 1'b0    // 1 hides shift key events
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          ps2_clk,
  input  logic                          ps2_data,
  input  logic                          rx_ready,
  output logic                          rx_valid,
  output logic                          rx_extended,
  output logic                          rx_released,
  output logic                          rx_shift_on,
  output keyboard_code_pkg::scan_code_t rx_scan_code,
  output keyboard_code_pkg::ascii_t     rx_ascii
);

  logic                          frame_valid;
  ps2_frame_pkg::frame_u         frame;
  logic                          key_valid;
  logic                          extended;
  logic                          released;
  keyboard_code_pkg::scan_code_t scan_code;
  keyboard_code_pkg::ascii_t     ascii;

  ps2_frame_receiver #(
    .watchdog_cycles (watchdog_cycles)
  ) i_receiver (
    .clk         (clk),
    .reset       (reset),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  // shift state goes straight out as rx_shift_on
  scan_code_decoder #(
    .trap_shift_keys (trap_shift_keys)
  ) i_decoder (
    .clk         (clk),
    .reset       (reset),
    .frame_valid (frame_valid),
    .frame       (frame),
    .key_valid   (key_valid),
    .extended    (extended),
    .released    (released),
    .shift_on    (rx_shift_on),
    .scan_code   (scan_code)
  );

  ascii_translator i_translator (
    .scan_code (scan_code),
    .shift_on  (rx_shift_on),
    .ascii     (ascii)
  );

  key_event_buffer i_buffer (
    .clk          (clk),
    .reset        (reset),
    .key_valid    (key_valid),
    .extended     (extended),
    .released     (released),
    .scan_code    (scan_code),
    .ascii        (ascii),
    .rx_ready     (rx_ready),
    .rx_valid     (rx_valid),
    .rx_extended  (rx_extended),
    .rx_released  (rx_released),
    .rx_scan_code (rx_scan_code),
    .rx_ascii     (rx_ascii)
  );

endmodule

`default_nettype wire

// ==== logic/key_event_buffer.sv ====
/*
  One-entry output register with valid/ready. No back-pressure reaches the
  decoder, so an event arriving while a stalled one is held is lost.
*/
`default_nettype none

module key_event_buffer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          key_valid,
  input  logic                          extended,
  input  logic                          released,
  input  keyboard_code_pkg::scan_code_t scan_code,
  input  keyboard_code_pkg::ascii_t     ascii,
  input  logic                          rx_ready,
  output logic                          rx_valid,
  output logic                          rx_extended,
  output logic                          rx_released,
  output keyboard_code_pkg::scan_code_t rx_scan_code,
  output keyboard_code_pkg::ascii_t     rx_ascii
);

  logic load;

  // empty, or draining this cycle, so the slot is free
  assign load = key_valid && (!rx_valid || rx_ready);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_valid     <= 1'b0;
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
      rx_scan_code <= '0;
      rx_ascii     <= '0;
    end
    else if (load)
    begin
      rx_valid     <= 1'b1;
      rx_extended  <= extended;
      rx_released  <= released;
      rx_scan_code <= scan_code;
      rx_ascii     <= ascii;
    end
    else if (rx_ready)
      rx_valid <= 1'b0;                      // transfer, nothing new behind it
  end

endmodule

`default_nettype wire

// ==== logic/ascii_translator.sv ====
/*
  US layout subset: control keys, space, digits, letters and a few
  punctuation keys. Everything else, keypad included, gives unknown_ascii.
*/
`default_nettype none

module ascii_translator (
  input  keyboard_code_pkg::scan_code_t scan_code,
  input  logic                          shift_on,
  output keyboard_code_pkg::ascii_t     ascii
);

  always_comb
  begin
    ascii = keyboard_code_pkg::unknown_ascii;
    case (scan_code)
      // shift has no effect on these
      8'h66: ascii = 8'h08;                          // backspace
      8'h0D: ascii = 8'h09;                          // tab
      8'h5A: ascii = 8'h0D;                          // enter
      8'h76: ascii = 8'h1B;                          // escape
      8'h29: ascii = 8'h20;                          // space
      8'h71: ascii = 8'h7F;                          // delete
      // ------------------------------
      // digit row
      // ------------------------------
      8'h16: ascii = shift_on ? 8'h21 : 8'h31;       // 1 !
      8'h1E: ascii = shift_on ? 8'h40 : 8'h32;       // 2 @
      8'h26: ascii = shift_on ? 8'h23 : 8'h33;       // 3 #
      8'h25: ascii = shift_on ? 8'h24 : 8'h34;       // 4 $
      8'h2E: ascii = shift_on ? 8'h25 : 8'h35;       // 5 %
      8'h36: ascii = shift_on ? 8'h5E : 8'h36;       // 6 ^
      8'h3D: ascii = shift_on ? 8'h26 : 8'h37;       // 7 &
      8'h3E: ascii = shift_on ? 8'h2A : 8'h38;       // 8 *
      8'h46: ascii = shift_on ? 8'h28 : 8'h39;       // 9 (
      8'h45: ascii = shift_on ? 8'h29 : 8'h30;       // 0 )
      // ------------------------------
      // letters, upper case with shift
      // ------------------------------
      8'h1C: ascii = shift_on ? 8'h41 : 8'h61;       // a
      8'h32: ascii = shift_on ? 8'h42 : 8'h62;       // b
      8'h21: ascii = shift_on ? 8'h43 : 8'h63;       // c
      8'h23: ascii = shift_on ? 8'h44 : 8'h64;       // d
      8'h24: ascii = shift_on ? 8'h45 : 8'h65;       // e
      8'h2B: ascii = shift_on ? 8'h46 : 8'h66;       // f
      8'h34: ascii = shift_on ? 8'h47 : 8'h67;       // g
      8'h33: ascii = shift_on ? 8'h48 : 8'h68;       // h
      8'h43: ascii = shift_on ? 8'h49 : 8'h69;       // i
      8'h3B: ascii = shift_on ? 8'h4A : 8'h6A;       // j
      8'h42: ascii = shift_on ? 8'h4B : 8'h6B;       // k
      8'h4B: ascii = shift_on ? 8'h4C : 8'h6C;       // l
      8'h3A: ascii = shift_on ? 8'h4D : 8'h6D;       // m
      8'h31: ascii = shift_on ? 8'h4E : 8'h6E;       // n
      8'h44: ascii = shift_on ? 8'h4F : 8'h6F;       // o
      8'h4D: ascii = shift_on ? 8'h50 : 8'h70;       // p
      8'h15: ascii = shift_on ? 8'h51 : 8'h71;       // q
      8'h2D: ascii = shift_on ? 8'h52 : 8'h72;       // r
      8'h1B: ascii = shift_on ? 8'h53 : 8'h73;       // s
      8'h2C: ascii = shift_on ? 8'h54 : 8'h74;       // t
      8'h3C: ascii = shift_on ? 8'h55 : 8'h75;       // u
      8'h2A: ascii = shift_on ? 8'h56 : 8'h76;       // v
      8'h1D: ascii = shift_on ? 8'h57 : 8'h77;       // w
      8'h22: ascii = shift_on ? 8'h58 : 8'h78;       // x
      8'h35: ascii = shift_on ? 8'h59 : 8'h79;       // y
      8'h1A: ascii = shift_on ? 8'h5A : 8'h7A;       // z
      // punctuation
      8'h41: ascii = shift_on ? 8'h3C : 8'h2C;       // , <
      8'h49: ascii = shift_on ? 8'h3E : 8'h2E;       // . >
      8'h4A: ascii = shift_on ? 8'h3F : 8'h2F;       // / ?
      8'h4C: ascii = shift_on ? 8'h3A : 8'h3B;       // ; :
      8'h52: ascii = shift_on ? 8'h22 : 8'h27;       // ' "
      8'h4E: ascii = shift_on ? 8'h5F : 8'h2D;       // - _
      8'h55: ascii = shift_on ? 8'h2B : 8'h3D;       // = +
      default: ascii = keyboard_code_pkg::unknown_ascii;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/scan_code_decoder.sv ====
/*
  Handles E0 and F0 prefixes and the two shift keys. Prefix state is held
  until the next non-prefix code. With trap_shift_keys set, shift keys only
  update shift_on and produce no key event.
*/
`default_nettype none

module scan_code_decoder #(
  parameter bit trap_shift_keys = 1'b0
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         frame_valid,
  input  ps2_frame_pkg::frame_u        frame,
  output logic                         key_valid,
  output logic                         extended,
  output logic                         released,
  output logic                         shift_on,
  output keyboard_code_pkg::scan_code_t scan_code
);

  keyboard_code_pkg::scan_code_t data_byte;
  logic is_extend;
  logic is_release;
  logic is_prefix;
  logic is_left;
  logic is_right;
  logic hold_extended;   // E0 seen, waiting for the key code
  logic hold_released;   // F0 seen, waiting for the key code
  logic left_shift;
  logic right_shift;

  assign data_byte  = frame.fields.data;
  assign is_extend  = (data_byte == keyboard_code_pkg::extend_code);
  assign is_release = (data_byte == keyboard_code_pkg::release_code);
  assign is_prefix  = is_extend | is_release;
  assign is_left    = (data_byte == keyboard_code_pkg::left_shift_code);
  assign is_right   = (data_byte == keyboard_code_pkg::right_shift_code);

  // ------------------------------
  // control state
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
      left_shift    <= 1'b0;
      right_shift   <= 1'b0;
      key_valid     <= 1'b0;
    end
    else
    begin
      key_valid <= frame_valid && !is_prefix
                   && !(trap_shift_keys && (is_left || is_right));
      if (frame_valid)
      begin
        if (is_prefix)
        begin
          hold_extended <= hold_extended | is_extend;
          hold_released <= hold_released | is_release;
        end
        else
        begin
          hold_extended <= 1'b0;             // any real code ends the sequence
          hold_released <= 1'b0;
        end
        if (is_left)  left_shift  <= !hold_released;   // make sets, break clears
        if (is_right) right_shift <= !hold_released;
      end
    end
  end

  // event payload, latched with the pulse
  always_ff @(posedge clk)
  begin
    if (frame_valid && !is_prefix)
    begin
      extended  <= hold_extended;
      released  <= hold_released;
      scan_code <= data_byte;
    end
  end

  assign shift_on = left_shift | right_shift;

endmodule

`default_nettype wire

// ==== logic/ps2_frame_receiver.sv ====
/*
  Receives keyboard-to-host frames only. clk must run well above ps2_clk
  (at least 4x). Parity and stop bit are not checked. A partial frame is
  dropped after watchdog_cycles idle clocks with ps2_clk high.
*/
`default_nettype none

module ps2_frame_receiver #(
  parameter int watchdog_cycles = 102   // idle clocks before a partial frame is cleared
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ps2_clk,
  input  logic                  ps2_data,
  output logic                  frame_valid,
  output ps2_frame_pkg::frame_u frame
);

  localparam int wd_bits = $clog2(watchdog_cycles + 1);

  logic [1:0]                clk_sync;    // [1] is the synchronized ps2_clk
  logic [1:0]                data_sync;
  logic                      clk_last;    // previous synchronized ps2_clk
  logic                      falling;
  ps2_frame_pkg::bit_count_t bit_count;
  logic [wd_bits-1:0]        wd_count;
  logic                      wd_expired;

  // ------------------------------
  // input synchronizers
  // ------------------------------
  // lines idle high, so reset to 1 to avoid a false edge
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_last  <= 1'b1;
    end
    else
    begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_last  <= clk_sync[1];
    end
  end

  assign falling = clk_last & ~clk_sync[1];  // one cycle per falling edge

  // ------------------------------
  // bit counter and shift register
  // ------------------------------
  assign frame_valid = (bit_count == ps2_frame_pkg::bit_count_t'(ps2_frame_pkg::frame_bits));

  always_ff @(posedge clk)
  begin
    if (reset || frame_valid || wd_expired)
      bit_count <= '0;                       // frame done or line went quiet
    else if (falling)
      bit_count <= bit_count + 1'b1;
  end

  // new bit enters at the top, so bit 0 ends up holding the start bit
  always_ff @(posedge clk)
  begin
    if (falling)
      frame.raw <= {data_sync[1], frame.raw[ps2_frame_pkg::frame_bits-1:1]};
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  // runs only mid-frame while ps2_clk sits high, low phase restarts it
  assign wd_expired = (wd_count == wd_bits'(watchdog_cycles - 1));

  always_ff @(posedge clk)
  begin
    if (reset || !clk_sync[1] || (bit_count == '0))
      wd_count <= '0;
    else if (!wd_expired)
      wd_count <= wd_count + 1'b1;           // holds at the limit
  end

endmodule

`default_nettype wire

// ==== logic/keyboard_code_pkg.sv ====
/*
  Scan code set 2 constants and character types. Only the prefixes and the
  two shift keys get names, every other code is plain data.
*/
`default_nettype none

package keyboard_code_pkg;

  // ------------------------------
  // widths and types
  // ------------------------------
  localparam int scan_code_bits = 8;
  localparam int ascii_bits     = 8;

  typedef logic [scan_code_bits-1:0] scan_code_t;
  typedef logic [ascii_bits-1:0]     ascii_t;

  // ------------------------------
  // special scan codes
  // ------------------------------
  localparam scan_code_t extend_code      = 8'hE0;  // next code is an extended key
  localparam scan_code_t release_code     = 8'hF0;  // next code is a key release
  localparam scan_code_t left_shift_code  = 8'h12;
  localparam scan_code_t right_shift_code = 8'h59;

  // result for any code that has no entry in the table
  localparam ascii_t unknown_ascii = 8'h2E;         // '.'

endpackage

`default_nettype wire

// ==== logic/ps2_frame_pkg.sv ====
/*
  PS/2 device-to-host frame layout. Bits arrive LSB first, so after a full
  shift the start bit sits at bit 0 and the stop bit at the top.
*/
`default_nettype none

package ps2_frame_pkg;

  // ------------------------------
  // frame geometry
  // ------------------------------
  localparam int frame_bits = 11;       // start + 8 data + parity + stop

  typedef logic [3:0] bit_count_t;      // counts 0..frame_bits

  // field order matches the shift direction, msb first
  typedef struct packed {
    logic       stop;                   // always 1 on the wire
    logic       parity;                 // odd parity, not checked here
    logic [7:0] data;                   // scan code byte
    logic       start;                  // always 0 on the wire
  } frame_fields_t;

  // the receiver shifts the raw word, the decoder reads the fields
  typedef union packed {
    logic [frame_bits-1:0] raw;
    frame_fields_t         fields;
  } frame_u;

endpackage

`default_nettype wire
